// ==== hw/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Register numbers with a fixed role
`define CORE_R14 4'd14
`define CORE_R15 4'd15

// Vector base after reset
`define CORE_VECTOR_RESET 32'h0000_0008

// AXI4-Lite byte addresses, register n sits at CSR_REG_BASE + 4n
`define CSR_VECTOR    32'h0000_0000
`define CSR_EXC_COUNT 32'h0000_0004
`define CSR_FLAGS     32'h0000_0008
`define CSR_REG_BASE  32'h0000_0040

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_ORR,
		OP_MOV,
		OP_UMULL,
		OP_LDR,
		OP_LDR_WB,
		OP_SWI
	} alu_op;

	typedef enum logic [2:0] {
		CYC_IDLE,
		CYC_ISSUE,
		CYC_TRANSFER,
		CYC_BASE_WB,
		CYC_MUL,
		CYC_MUL_HI_WB,
		CYC_EXCEPTION
	} ctrl_state;

	typedef struct packed {
		alu_op       op;
		reg_num      rd;
		reg_num      rn;
		reg_num      rm;
		reg_num      rd_hi;
		logic [11:0] imm;
		logic        use_imm;
		logic        update_flags;
		logic        writeback;
		word         pc;
	} insn_decode;

	typedef struct packed {
		logic valid;
		word  addr;
	} mem_req;

	typedef struct packed {
		logic       awvalid;
		word        awaddr;
		logic       wvalid;
		word        wdata;
		logic [3:0] wstrb;
		logic       bready;
		logic       arvalid;
		word        araddr;
		logic       rready;
	} axil_req;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		word        rdata;
		logic [1:0] rresp;
	} axil_rsp;

endpackage

`default_nettype wire

// ==== hw/core_cycle_ctrl.sv ====
`default_nettype none

module core_cycle_ctrl (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 insn_valid,
	input  wire core_pkg::insn_decode insn,
	input  wire logic                 mem_ready,
	input  wire core_pkg::word        load_addr,
	output logic                      insn_ready,
	output core_pkg::insn_decode      dec,
	output core_pkg::ctrl_state       cycle,
	output core_pkg::ctrl_state       next_cycle,
	output logic                      issue,
	output logic                      exc_phase,
	output core_pkg::mem_req          mem
);

	logic accept;
	logic mem_valid_q;

	assign insn_ready = (cycle == core_pkg::CYC_IDLE);
	assign accept = insn_valid && insn_ready;

	// The address comes from the registered base, which holds while rn is unchanged
	assign mem = '{valid: mem_valid_q, addr: load_addr};

	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			core_pkg::CYC_IDLE:
				if (accept)
					next_cycle = core_pkg::CYC_ISSUE;
			core_pkg::CYC_ISSUE:
				case (dec.op)
					core_pkg::OP_UMULL:
						next_cycle = core_pkg::CYC_MUL;
					core_pkg::OP_LDR, core_pkg::OP_LDR_WB:
						next_cycle = core_pkg::CYC_TRANSFER;
					core_pkg::OP_SWI:
						next_cycle = core_pkg::CYC_EXCEPTION;
					default:
						next_cycle = core_pkg::CYC_IDLE;
				endcase
			core_pkg::CYC_TRANSFER:
				if (mem_ready) begin
					if (dec.op == core_pkg::OP_LDR_WB)
						next_cycle = core_pkg::CYC_BASE_WB;
					else
						next_cycle = core_pkg::CYC_IDLE;
				end
			core_pkg::CYC_MUL:
				next_cycle = core_pkg::CYC_MUL_HI_WB;
			core_pkg::CYC_EXCEPTION:
				if (exc_phase)
					next_cycle = core_pkg::CYC_IDLE;
			default:
				next_cycle = core_pkg::CYC_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= core_pkg::CYC_IDLE;
			issue <= 1'b0;
			exc_phase <= 1'b0;
			mem_valid_q <= 1'b0;
		end else begin
			cycle <= next_cycle;
			issue <= accept;
			// Second exception cycle is marked by the phase bit
			exc_phase <= (cycle == core_pkg::CYC_EXCEPTION) && !exc_phase;
			mem_valid_q <= (next_cycle == core_pkg::CYC_TRANSFER);
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dec <= insn;
	end

endmodule

`default_nettype wire

// ==== hw/core_execute.sv ====
`default_nettype none

module core_execute (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire core_pkg::insn_decode dec,
	input  wire core_pkg::word        op_a,
	input  wire core_pkg::word        op_b,
	output core_pkg::word             q_alu,
	output core_pkg::psr_flags        alu_flags,
	output core_pkg::word             mul_q_hi,
	output core_pkg::word             mul_q_lo,
	output core_pkg::word             saved_base
);

	core_pkg::word b_val;
	core_pkg::word sum;
	core_pkg::word diff;
	core_pkg::word imm_ext;
	logic          carry_add;
	logic          borrow;
	logic [63:0]   prod_q;

	assign imm_ext = {20'd0, dec.imm};
	assign b_val = dec.use_imm ? imm_ext : op_b;
	assign {carry_add, sum} = {1'b0, op_a} + {1'b0, b_val};
	assign {borrow, diff} = {1'b0, op_a} - {1'b0, b_val};

	always_comb begin
		alu_flags = '0;
		unique case (dec.op)
			core_pkg::OP_ADD: begin
				q_alu = sum;
				alu_flags.c = carry_add;
				alu_flags.v = (op_a[31] == b_val[31]) && (sum[31] != op_a[31]);
			end
			core_pkg::OP_SUB: begin
				q_alu = diff;
				// ARM carry on subtract means no borrow
				alu_flags.c = !borrow;
				alu_flags.v = (op_a[31] != b_val[31]) && (diff[31] != op_a[31]);
			end
			core_pkg::OP_AND: q_alu = op_a & b_val;
			core_pkg::OP_ORR: q_alu = op_a | b_val;
			core_pkg::OP_MOV: q_alu = b_val;
			default:          q_alu = sum;
		endcase
		alu_flags.n = q_alu[31];
		alu_flags.z = (q_alu == '0);
	end

	// Operands stay unchanged until the cycle that writes the first result,
	// so recapturing each cycle keeps the value stable for the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_q <= '0;
			saved_base <= '0;
		end else begin
			if (dec.op == core_pkg::OP_UMULL)
				prod_q <= op_a * op_b;
			if (dec.op inside {core_pkg::OP_LDR, core_pkg::OP_LDR_WB})
				saved_base <= op_a + imm_ext;
		end
	end

	assign mul_q_hi = prod_q[63:32];
	assign mul_q_lo = prod_q[31:0];

endmodule

`default_nettype wire

// ==== hw/core_control_writeback.sv ====
`default_nettype none

`include "core_config.svh"

module core_control_writeback (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire core_pkg::insn_decode dec,
	input  wire core_pkg::ctrl_state  cycle,
	input  wire core_pkg::ctrl_state  next_cycle,
	input  wire logic                 issue,
	input  wire logic                 mem_ready,
	input  wire logic                 exc_phase,
	input  wire core_pkg::word        q_alu,
	input  wire core_pkg::word        mem_rdata,
	input  wire core_pkg::word        mul_q_hi,
	input  wire core_pkg::word        mul_q_lo,
	input  wire core_pkg::word        saved_base,
	input  wire core_pkg::word        vector,
	output core_pkg::reg_num          rd,
	output logic                      writeback,
	output logic                      update_flags,
	output core_pkg::word             wr_value,
	output logic                      exc_taken
);

	core_pkg::reg_num final_rd;
	logic             final_writeback;
	logic             issue_done;

	// Only instructions that finish in the issue cycle commit there
	assign issue_done = (next_cycle == core_pkg::CYC_IDLE);

	assign exc_taken = (cycle == core_pkg::CYC_EXCEPTION) && !exc_phase;

	always_comb begin
		rd = final_rd;
		writeback = 1'b0;
		update_flags = 1'b0;
		wr_value = q_alu;
		unique case (cycle)
			core_pkg::CYC_ISSUE: begin
				rd = dec.rd;
				writeback = dec.writeback && issue_done;
				update_flags = dec.update_flags && issue_done;
			end
			core_pkg::CYC_TRANSFER: begin
				writeback = final_writeback && mem_ready;
				wr_value = mem_rdata;
			end
			core_pkg::CYC_BASE_WB: begin
				rd = dec.rn;
				writeback = 1'b1;
				wr_value = saved_base;
			end
			core_pkg::CYC_MUL: begin
				writeback = final_writeback;
				wr_value = mul_q_lo;
			end
			core_pkg::CYC_MUL_HI_WB: begin
				rd = dec.rd_hi;
				writeback = final_writeback;
				wr_value = mul_q_hi;
			end
			core_pkg::CYC_EXCEPTION: begin
				// Return address first, then the jump to the vector
				writeback = 1'b1;
				if (exc_phase) begin
					rd = `CORE_R15;
					wr_value = vector;
				end else begin
					rd = `CORE_R14;
					wr_value = dec.pc + 32'd4;
				end
			end
			default: begin
				rd = final_rd;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			final_rd <= '0;
			final_writeback <= 1'b0;
		end else if (issue) begin
			final_rd <= dec.rd;
			final_writeback <= dec.writeback;
		end
	end

endmodule

`default_nettype wire

// ==== hw/core_regfile.sv ====
`default_nettype none

module core_regfile (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire core_pkg::reg_num   rs_a,
	input  wire core_pkg::reg_num   rs_b,
	input  wire core_pkg::reg_num   dbg_sel,
	input  wire logic               wr_en,
	input  wire core_pkg::reg_num   wr_sel,
	input  wire core_pkg::word      wr_value,
	input  wire logic               flags_en,
	input  wire core_pkg::psr_flags flags_in,
	output core_pkg::word           rd_a,
	output core_pkg::word           rd_b,
	output core_pkg::word           dbg_value,
	output core_pkg::psr_flags      flags
);

	core_pkg::word regs [16];

	assign rd_a = regs[rs_a];
	assign rd_b = regs[rs_b];
	assign dbg_value = regs[dbg_sel];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (wr_en)
				regs[wr_sel] <= wr_value;
			if (flags_en)
				flags <= flags_in;
		end
	end

endmodule

`default_nettype wire

// ==== hw/core_csr_axil.sv ====
`default_nettype none

`include "core_config.svh"

module core_csr_axil (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire core_pkg::axil_req  axil_in,
	input  wire logic               exc_taken,
	input  wire core_pkg::word      dbg_value,
	input  wire core_pkg::psr_flags flags,
	output core_pkg::axil_rsp       axil_out,
	output core_pkg::word           vector,
	output core_pkg::reg_num        dbg_sel
);

	logic          wr_hs;
	logic          rd_hs;
	logic          bvalid_q;
	logic          rvalid_q;
	core_pkg::word rdata_q;
	core_pkg::word rd_mux;
	core_pkg::word exc_count;

	// A write needs both address and data, and no B response still pending
	assign wr_hs = axil_in.awvalid && axil_in.wvalid && !bvalid_q;
	assign rd_hs = axil_in.arvalid && !rvalid_q;

	assign dbg_sel = axil_in.araddr[5:2];

	always_comb begin
		rd_mux = '0;
		if ((axil_in.araddr & ~32'h0000_003F) == `CSR_REG_BASE)
			rd_mux = dbg_value;
		else
			case (axil_in.araddr)
				`CSR_VECTOR:    rd_mux = vector;
				`CSR_EXC_COUNT: rd_mux = exc_count;
				`CSR_FLAGS:     rd_mux = {28'd0, flags};
				default:        rd_mux = '0;
			endcase
	end

	always_comb begin
		axil_out = '0;
		axil_out.awready = wr_hs;
		axil_out.wready = wr_hs;
		axil_out.bvalid = bvalid_q;
		axil_out.bresp = 2'b00;
		axil_out.arready = rd_hs;
		axil_out.rvalid = rvalid_q;
		axil_out.rdata = rdata_q;
		axil_out.rresp = 2'b00;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			vector <= `CORE_VECTOR_RESET;
			exc_count <= '0;
		end else begin
			if (wr_hs)
				bvalid_q <= 1'b1;
			else if (axil_in.bready)
				bvalid_q <= 1'b0;

			if (rd_hs)
				rvalid_q <= 1'b1;
			else if (axil_in.rready)
				rvalid_q <= 1'b0;

			if (wr_hs && axil_in.awaddr == `CSR_VECTOR) begin
				for (int i = 0; i < 4; i++)
					if (axil_in.wstrb[i])
						vector[8*i +: 8] <= axil_in.wdata[8*i +: 8];
			end

			if (exc_taken)
				exc_count <= exc_count + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs)
			rdata_q <= rd_mux;
	end

endmodule

`default_nettype wire

// ==== hw/core_wb_top.sv ====
`default_nettype none

module core_wb_top (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 insn_valid,
	input  wire core_pkg::insn_decode insn,
	input  wire logic                 mem_ready,
	input  wire core_pkg::word        mem_rdata,
	input  wire core_pkg::axil_req    axil_in,
	output logic                      insn_ready,
	output core_pkg::mem_req          mem,
	output core_pkg::axil_rsp         axil_out
);

	core_pkg::insn_decode dec;
	core_pkg::ctrl_state  cycle;
	core_pkg::ctrl_state  next_cycle;
	logic                 issue;
	logic                 exc_phase;
	core_pkg::word        op_a;
	core_pkg::word        op_b;
	core_pkg::word        q_alu;
	core_pkg::psr_flags   alu_flags;
	core_pkg::word        mul_q_hi;
	core_pkg::word        mul_q_lo;
	core_pkg::word        saved_base;
	core_pkg::reg_num     wb_rd;
	logic                 wb_en;
	logic                 wb_flags_en;
	core_pkg::word        wr_value;
	logic                 exc_taken;
	core_pkg::word        vector;
	core_pkg::reg_num     dbg_sel;
	core_pkg::word        dbg_value;
	core_pkg::psr_flags   flags;

	core_cycle_ctrl u_cycle_ctrl (
		.clk, .rst_n, .insn_valid, .insn, .mem_ready,
		.load_addr(saved_base), .insn_ready, .dec, .cycle, .next_cycle,
		.issue, .exc_phase, .mem
	);

	core_execute u_execute (
		.clk, .rst_n, .dec, .op_a, .op_b,
		.q_alu, .alu_flags, .mul_q_hi, .mul_q_lo, .saved_base
	);

	core_control_writeback u_control_writeback (
		.clk, .rst_n, .dec, .cycle, .next_cycle, .issue, .mem_ready, .exc_phase,
		.q_alu, .mem_rdata, .mul_q_hi, .mul_q_lo, .saved_base, .vector,
		.rd(wb_rd), .writeback(wb_en), .update_flags(wb_flags_en), .wr_value, .exc_taken
	);

	core_regfile u_regfile (
		.clk, .rst_n, .rs_a(dec.rn), .rs_b(dec.rm), .dbg_sel,
		.wr_en(wb_en), .wr_sel(wb_rd), .wr_value, .flags_en(wb_flags_en),
		.flags_in(alu_flags), .rd_a(op_a), .rd_b(op_b), .dbg_value, .flags
	);

	core_csr_axil u_csr_axil (
		.clk, .rst_n, .axil_in, .exc_taken, .dbg_value, .flags,
		.axil_out, .vector, .dbg_sel
	);

endmodule

`default_nettype wire

// ==== tests/core_wb_props.sv ====
`default_nettype none

module core_wb_props (
	input wire logic                clk,
	input wire logic                rst_n,
	input wire logic                insn_valid,
	input wire logic                insn_ready,
	input wire core_pkg::ctrl_state cycle,
	input wire core_pkg::mem_req    mem,
	input wire logic                mem_ready,
	input wire logic                flags_en
);

	timeunit 1ns;
	timeprecision 100ps;

	// An accepted instruction closes the port for at least its issue cycle
	a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		(insn_valid && insn_ready) |=> !insn_ready)
		else $error("insn_ready still high in the cycle after an accept");

	// The port stays closed while a load is outstanding
	a_busy_during_load: assert property (@(posedge clk) disable iff (!rst_n)
		mem.valid |-> !insn_ready)
		else $error("insn_ready high while a load is pending");

	// A pending load keeps its request steady
	a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(mem.valid && !mem_ready) |=> $stable(mem))
		else $error("memory request changed while waiting for mem_ready");

	a_no_flags_in_exception: assert property (@(posedge clk) disable iff (!rst_n)
		(cycle == core_pkg::CYC_EXCEPTION) |-> !flags_en)
		else $error("flags updated in an exception cycle");

endmodule

`default_nettype wire

// ==== tests/core_wb_tb.sv ====
`default_nettype none

`include "core_config.svh"

module core_wb_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;

	logic                 clk;
	logic                 rst_n;
	logic                 insn_valid;
	core_pkg::insn_decode insn;
	logic                 mem_ready;
	core_pkg::word        mem_rdata;
	core_pkg::axil_req    axil_in;
	logic                 insn_ready;
	core_pkg::mem_req     mem;
	core_pkg::axil_rsp    axil_out;

	core_pkg::word      model_regs [16];
	core_pkg::psr_flags model_flags;
	logic [15:0]        lfsr_state;

	core_wb_top u_core_wb_top (
		.clk, .rst_n, .insn_valid, .insn, .mem_ready, .mem_rdata, .axil_in,
		.insn_ready, .mem, .axil_out
	);

	bind core_wb_top core_wb_props u_props (
		.clk, .rst_n, .insn_valid, .insn_ready, .cycle, .mem, .mem_ready,
		.flags_en(wb_flags_en)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog timeout, the tests did not finish in time");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic random_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Loads answer after 0 to 3 cycles with the address folded into the data
	initial begin
		int delay;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && mem.valid) begin
				random_bits(2, delay);
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				mem_ready = 1'b1;
				mem_rdata = mem.addr ^ 32'hA5A5_0000;
				@(posedge clk);
				#1;
				mem_ready = 1'b0;
			end
		end
	end

	task automatic check_eq(input string what, input core_pkg::word got,
			input core_pkg::word exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s read %h, expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic write_csr(input core_pkg::word addr, input core_pkg::word data);
		logic hs;
		axil_in.awvalid = 1'b1;
		axil_in.awaddr = addr;
		axil_in.wvalid = 1'b1;
		axil_in.wdata = data;
		axil_in.wstrb = 4'hF;
		axil_in.bready = 1'b1;
		do begin
			@(negedge clk);
			hs = axil_out.awready;
			@(posedge clk);
		end while (!hs);
		#1;
		axil_in.awvalid = 1'b0;
		axil_in.wvalid = 1'b0;
		do @(negedge clk); while (!axil_out.bvalid);
		check_eq("BRESP", {30'd0, axil_out.bresp}, 32'd0);
		@(posedge clk);
		#1;
		axil_in.bready = 1'b0;
	endtask

	task automatic read_csr(input core_pkg::word addr, output core_pkg::word data);
		logic hs;
		axil_in.arvalid = 1'b1;
		axil_in.araddr = addr;
		axil_in.rready = 1'b1;
		do begin
			@(negedge clk);
			hs = axil_out.arready;
			@(posedge clk);
		end while (!hs);
		#1;
		axil_in.arvalid = 1'b0;
		do @(negedge clk); while (!axil_out.rvalid);
		data = axil_out.rdata;
		check_eq("RRESP", {30'd0, axil_out.rresp}, 32'd0);
		@(posedge clk);
		#1;
		axil_in.rready = 1'b0;
	endtask

	task automatic check_reg(input int n);
		core_pkg::word val;
		read_csr(`CSR_REG_BASE + 4 * n, val);
		check_eq($sformatf("R%0d", n), val, model_regs[n]);
	endtask

	task automatic check_all_regs();
		for (int n = 0; n < 16; n++)
			check_reg(n);
	endtask

	task automatic check_flags();
		core_pkg::word val;
		read_csr(`CSR_FLAGS, val);
		check_eq("flags", val, {28'd0, model_flags});
	endtask

	// Cycles counts from the accept edge until insn_ready is seen again
	task automatic issue_insn(input core_pkg::insn_decode i, output int cycles);
		do @(negedge clk); while (!insn_ready);
		@(posedge clk);
		#1;
		insn = i;
		insn_valid = 1'b1;
		@(posedge clk);
		#1;
		insn_valid = 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!insn_ready);
		@(posedge clk);
		#1;
	endtask

	function automatic core_pkg::insn_decode make_insn(input core_pkg::alu_op op,
			input core_pkg::reg_num rd, input core_pkg::reg_num rn,
			input core_pkg::reg_num rm, input logic [11:0] imm, input logic use_imm,
			input logic uf);
		core_pkg::insn_decode i;
		i = '0;
		i.op = op;
		i.rd = rd;
		i.rn = rn;
		i.rm = rm;
		i.imm = imm;
		i.use_imm = use_imm;
		i.update_flags = uf;
		i.writeback = 1'b1;
		return i;
	endfunction

	task automatic run_alu(input core_pkg::alu_op op, input core_pkg::reg_num rd,
			input core_pkg::reg_num rn, input core_pkg::reg_num rm,
			input logic [11:0] imm, input logic use_imm, input logic uf);
		core_pkg::word      a;
		core_pkg::word      b;
		core_pkg::word      r;
		core_pkg::psr_flags f;
		longint             s;
		int                 cycles;
		a = model_regs[rn];
		b = use_imm ? {20'd0, imm} : model_regs[rm];
		f = '0;
		case (op)
			core_pkg::OP_ADD: begin
				r = a + b;
				f.c = ({32'd0, a} + {32'd0, b}) > 64'hFFFF_FFFF;
				s = longint'(signed'(a)) + longint'(signed'(b));
			end
			core_pkg::OP_SUB: begin
				r = a - b;
				f.c = (a >= b);
				s = longint'(signed'(a)) - longint'(signed'(b));
			end
			core_pkg::OP_AND: r = a & b;
			core_pkg::OP_ORR: r = a | b;
			default:          r = b;
		endcase
		if (op inside {core_pkg::OP_ADD, core_pkg::OP_SUB})
			f.v = (s > 64'sd2147483647) || (s < -64'sd2147483648);
		f.n = r[31];
		f.z = (r == 0);
		issue_insn(make_insn(op, rd, rn, rm, imm, use_imm, uf), cycles);
		check_eq("ALU latency", cycles, 32'd2);
		model_regs[rd] = r;
		if (uf)
			model_flags = f;
		check_reg(rd);
		check_flags();
	endtask

	task automatic test_reset_values();
		core_pkg::word val;
		read_csr(`CSR_VECTOR, val);
		check_eq("vector after reset", val, `CORE_VECTOR_RESET);
		read_csr(`CSR_EXC_COUNT, val);
		check_eq("exception count after reset", val, 32'd0);
		check_flags();
		check_all_regs();
	endtask

	task automatic test_alu();
		run_alu(core_pkg::OP_MOV, 4'd1, 4'd0, 4'd0, 12'hFFF, 1'b1, 1'b1);
		run_alu(core_pkg::OP_ADD, 4'd2, 4'd1, 4'd0, 12'h001, 1'b1, 1'b1);
		run_alu(core_pkg::OP_SUB, 4'd3, 4'd1, 4'd0, 12'hFFF, 1'b1, 1'b1);
		run_alu(core_pkg::OP_SUB, 4'd4, 4'd0, 4'd0, 12'h001, 1'b1, 1'b1);
		run_alu(core_pkg::OP_AND, 4'd6, 4'd4, 4'd2, 12'h000, 1'b0, 1'b1);
		// Leaves Z and C set for the instructions after it
		run_alu(core_pkg::OP_ADD, 4'd5, 4'd4, 4'd0, 12'h001, 1'b1, 1'b1);
		// No flag update here, the previous flags must survive
		run_alu(core_pkg::OP_ORR, 4'd7, 4'd1, 4'd2, 12'h000, 1'b0, 1'b0);
		run_alu(core_pkg::OP_ORR, 4'd8, 4'd6, 4'd0, 12'h0F0, 1'b1, 1'b0);
	endtask

	task automatic test_umull();
		logic [63:0]          prod;
		core_pkg::insn_decode i;
		int                   cycles;
		prod = model_regs[4] * model_regs[2];
		i = make_insn(core_pkg::OP_UMULL, 4'd9, 4'd4, 4'd2, 12'd0, 1'b0, 1'b0);
		i.rd_hi = 4'd10;
		issue_insn(i, cycles);
		check_eq("UMULL latency", cycles, 32'd4);
		model_regs[9] = prod[31:0];
		model_regs[10] = prod[63:32];
		check_reg(9);
		check_reg(10);
		check_flags();
	endtask

	task automatic test_ldr();
		core_pkg::word addr;
		int            cycles;
		for (int k = 0; k < 4; k++) begin
			addr = model_regs[1] + 32'h20 * k;
			issue_insn(make_insn(core_pkg::OP_LDR, 4'd11, 4'd1, 4'd0, 12'(32'h20 * k),
				1'b1, 1'b0), cycles);
			model_regs[11] = addr ^ 32'hA5A5_0000;
			check_all_regs();
		end
	endtask

	task automatic test_ldr_wb();
		core_pkg::word addr;
		int            cycles;
		addr = model_regs[2] + 32'h10;
		issue_insn(make_insn(core_pkg::OP_LDR_WB, 4'd12, 4'd2, 4'd0, 12'h010, 1'b1, 1'b0),
			cycles);
		model_regs[12] = addr ^ 32'hA5A5_0000;
		model_regs[2] = addr;
		check_all_regs();
	endtask

	task automatic test_swi();
		core_pkg::word        val;
		core_pkg::insn_decode i;
		int                   cycles;
		write_csr(`CSR_VECTOR, 32'h0000_0100);
		read_csr(`CSR_VECTOR, val);
		check_eq("vector", val, 32'h0000_0100);
		i = make_insn(core_pkg::OP_SWI, 4'd0, 4'd0, 4'd0, 12'd0, 1'b0, 1'b0);
		i.pc = 32'h0000_0200;
		issue_insn(i, cycles);
		check_eq("SWI latency", cycles, 32'd4);
		model_regs[14] = 32'h0000_0204;
		model_regs[15] = 32'h0000_0100;
		check_all_regs();
		read_csr(`CSR_EXC_COUNT, val);
		check_eq("exception count", val, 32'd1);
		check_flags();
	endtask

	initial begin
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		axil_in = '0;
		lfsr_state = 16'd71;
		model_flags = '0;
		for (int n = 0; n < 16; n++)
			model_regs[n] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_values();
		test_alu();
		test_umull();
		test_ldr();
		test_ldr_wb();
		test_swi();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/core_pkg.sv
hw/core_cycle_ctrl.sv
hw/core_execute.sv
hw/core_control_writeback.sv
hw/core_regfile.sv
hw/core_csr_axil.sv
hw/core_wb_top.sv
tests/core_wb_props.sv
tests/core_wb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= core_wb_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
